/* hw/rv32i_pkg.sv */
package rv32i_pkg;

    // datapath width
    localparam int XLEN = 32;
    // register index width
    localparam int REG_ADDR_W = 5;
    // shift amount width, low bits of the second operand
    localparam int SHAMT_W = 5;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // x0 is hardwired to zero, writes to it are dropped
    localparam reg_addr_t REG_X0 = '0;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        // load upper immediate
        op_lui   = 7'b0110111,
        // add upper immediate to pc
        op_auipc = 7'b0010111,
        // jumps, flagged as traps here
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        // branch, flagged as trap
        op_br    = 7'b1100011,
        // memory ops, flagged as traps
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        // register-immediate arithmetic
        op_imm   = 7'b0010011,
        // register-register arithmetic
        op_reg   = 7'b0110011
    } opcode_t;

    // funct3 for op_imm and op_reg
    typedef enum logic [2:0] {
        // add or sub, sub only in op_reg with funct7[5]
        add  = 3'b000,
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        // srl or sra picked by funct7[5]
        sr   = 3'b101,
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    // alu operations
    // add, sll, xor, or, and share their funct3 encoding,
    // so decode can cast funct3 straight into this type
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_t;

    // comparator operations, same codes as the branch funct3 for blt/bltu
    typedef enum logic [2:0] {
        cmp_lt  = 3'b100,
        cmp_ltu = 3'b110
    } cmp_op_t;

    // writeback value source
    typedef enum logic [1:0] {
        res_alu  = 2'b00,
        res_cmp  = 2'b01,
        res_uimm = 2'b10
    } result_sel_t;

    // first alu operand
    typedef enum logic {
        src1_rs1 = 1'b0,
        src1_pc  = 1'b1
    } alu_src1_t;

    // second alu and comparator operand
    typedef enum logic [1:0] {
        src2_rs2  = 2'b00,
        src2_iimm = 2'b01,
        src2_uimm = 2'b10
    } alu_src2_t;

    // pipeline input, one instruction with its operands
    typedef struct packed {
        word_t instr;
        word_t pc;
        // values read from the external register file
        word_t rs1_val;
        word_t rs2_val;
    } issue_t;

    // decode to execute packet
    typedef struct packed {
        alu_op_t     aluop;
        cmp_op_t     cmpop;
        alu_src1_t   src1;
        alu_src2_t   src2;
        result_sel_t result_sel;
        // i or u immediate, whichever the opcode uses
        word_t       imm;
        word_t       pc;
        word_t       rs1_val;
        word_t       rs2_val;
        reg_addr_t   rd;
        // register write enable, low for x0 and traps
        logic        we;
        // unsupported opcode
        logic        trap;
    } exec_ctrl_t;

    // pipeline output, the writeback packet
    typedef struct packed {
        reg_addr_t rd;
        word_t     value;
        logic      we;
        logic      trap;
    } wb_t;

endpackage : rv32i_pkg

/* hw/pipe_reg.sv */
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    // upstream side
    input  logic     i_valid,
    output logic     o_ready,
    input  payload_t i_data,
    // downstream side
    output logic     o_valid,
    input  logic     i_ready,
    output payload_t o_data
);

    logic     valid_q;
    payload_t data_q;
    logic     load;

    // take new data when empty or when the held item leaves this cycle
    assign o_ready = ~valid_q | i_ready;
    assign load    = i_valid & o_ready;

    // occupancy bit
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (o_ready) begin
            // refill or go empty when draining
            valid_q <= i_valid;
        end
    end

    // payload only moves on an accepted transfer, held stable otherwise
    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= i_data;
        end
    end

    assign o_valid = valid_q;
    assign o_data  = data_q;

endmodule : pipe_reg

/* hw/decode_stage.sv */
module decode_stage (
    input  logic                   clk,
    input  logic                   rst,
    // issue side
    input  logic                   i_valid,
    output logic                   o_ready,
    input  rv32i_pkg::issue_t      i_issue,
    // execute side
    output logic                   o_valid,
    input  logic                   i_ready,
    output rv32i_pkg::exec_ctrl_t  o_ctrl
);

    rv32i_pkg::opcode_t      opcode;
    rv32i_pkg::arith_funct3_t funct3;
    logic                    funct7_b5;
    rv32i_pkg::reg_addr_t    rd;
    rv32i_pkg::word_t        i_imm;
    rv32i_pkg::word_t        u_imm;
    rv32i_pkg::exec_ctrl_t   ctrl_d;

    // instruction fields
    assign opcode    = rv32i_pkg::opcode_t'(i_issue.instr[6:0]);
    assign funct3    = rv32i_pkg::arith_funct3_t'(i_issue.instr[14:12]);
    // bit 30, sub and sra select
    assign funct7_b5 = i_issue.instr[30];
    assign rd        = i_issue.instr[11:7];
    // sign extended i immediate
    assign i_imm     = {{(rv32i_pkg::XLEN-12){i_issue.instr[31]}}, i_issue.instr[31:20]};
    // u immediate already in place
    assign u_imm     = {i_issue.instr[31:12], 12'b0};

    always_comb begin
        // defaults, rs1 op i_imm through the alu
        ctrl_d.aluop      = rv32i_pkg::alu_add;
        ctrl_d.cmpop      = rv32i_pkg::cmp_lt;
        ctrl_d.src1       = rv32i_pkg::src1_rs1;
        ctrl_d.src2       = rv32i_pkg::src2_iimm;
        ctrl_d.result_sel = rv32i_pkg::res_alu;
        ctrl_d.imm        = i_imm;
        ctrl_d.pc         = i_issue.pc;
        ctrl_d.rs1_val    = i_issue.rs1_val;
        ctrl_d.rs2_val    = i_issue.rs2_val;
        ctrl_d.rd         = rd;
        ctrl_d.we         = 1'b1;
        ctrl_d.trap       = 1'b0;

        case (opcode)
            rv32i_pkg::op_lui: begin
                // value is the u immediate itself
                ctrl_d.imm        = u_imm;
                ctrl_d.result_sel = rv32i_pkg::res_uimm;
            end

            rv32i_pkg::op_auipc: begin
                // pc + u immediate
                ctrl_d.imm   = u_imm;
                ctrl_d.src1  = rv32i_pkg::src1_pc;
                ctrl_d.src2  = rv32i_pkg::src2_uimm;
                ctrl_d.aluop = rv32i_pkg::alu_add;
            end

            rv32i_pkg::op_imm, rv32i_pkg::op_reg: begin
                // reg-reg uses rs2 for both alu and comparator
                if (opcode == rv32i_pkg::op_reg) begin
                    ctrl_d.src2 = rv32i_pkg::src2_rs2;
                end
                case (funct3)
                    rv32i_pkg::add: begin
                        // addi never subtracts, funct7 bits are immediate there
                        if (opcode == rv32i_pkg::op_reg && funct7_b5) begin
                            ctrl_d.aluop = rv32i_pkg::alu_sub;
                        end else begin
                            ctrl_d.aluop = rv32i_pkg::alu_add;
                        end
                    end
                    rv32i_pkg::slt: begin
                        ctrl_d.result_sel = rv32i_pkg::res_cmp;
                        ctrl_d.cmpop      = rv32i_pkg::cmp_lt;
                    end
                    rv32i_pkg::sltu: begin
                        ctrl_d.result_sel = rv32i_pkg::res_cmp;
                        ctrl_d.cmpop      = rv32i_pkg::cmp_ltu;
                    end
                    rv32i_pkg::sr: begin
                        // arithmetic shift when bit 30 set, also for srai
                        if (funct7_b5) begin
                            ctrl_d.aluop = rv32i_pkg::alu_sra;
                        end else begin
                            ctrl_d.aluop = rv32i_pkg::alu_srl;
                        end
                    end
                    default: begin
                        // sll, xor, or, and map 1:1 onto the alu encoding
                        ctrl_d.aluop = rv32i_pkg::alu_op_t'(funct3);
                    end
                endcase
            end

            default: begin
                // loads, stores, branches, jumps and anything unknown
                ctrl_d.trap = 1'b1;
                ctrl_d.we   = 1'b0;
            end
        endcase

        // x0 stays zero
        if (rd == rv32i_pkg::REG_X0) begin
            ctrl_d.we = 1'b0;
        end
    end

    // one cycle stage register
    pipe_reg #(
        .payload_t(rv32i_pkg::exec_ctrl_t)
    ) i_pipe_reg (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .i_data  (ctrl_d),
        .o_valid (o_valid),
        .i_ready (i_ready),
        .o_data  (o_ctrl)
    );

endmodule : decode_stage

/* hw/execute_stage.sv */
module execute_stage (
    input  logic                  clk,
    input  logic                  rst,
    // decode side
    input  logic                  i_valid,
    output logic                  o_ready,
    input  rv32i_pkg::exec_ctrl_t i_ctrl,
    // writeback side
    output logic                  o_valid,
    input  logic                  i_ready,
    output rv32i_pkg::wb_t        o_wb
);

    rv32i_pkg::word_t                   op_a;
    rv32i_pkg::word_t                   op_b;
    logic [rv32i_pkg::SHAMT_W-1:0]      shamt;
    rv32i_pkg::word_t                   alu_out;
    logic                               cmp_out;
    rv32i_pkg::word_t                   result;
    rv32i_pkg::wb_t                     wb_d;

    // operand muxes
    assign op_a = (i_ctrl.src1 == rv32i_pkg::src1_pc) ? i_ctrl.pc : i_ctrl.rs1_val;

    always_comb begin
        case (i_ctrl.src2)
            rv32i_pkg::src2_rs2: op_b = i_ctrl.rs2_val;
            // i or u immediate, decode puts the one in use into imm
            default:             op_b = i_ctrl.imm;
        endcase
    end

    // only the low bits count for shifts
    assign shamt = op_b[rv32i_pkg::SHAMT_W-1:0];

    // alu
    always_comb begin
        case (i_ctrl.aluop)
            rv32i_pkg::alu_add: alu_out = op_a + op_b;
            rv32i_pkg::alu_sll: alu_out = op_a << shamt;
            rv32i_pkg::alu_sra: alu_out = rv32i_pkg::word_t'($signed(op_a) >>> shamt);
            rv32i_pkg::alu_sub: alu_out = op_a - op_b;
            rv32i_pkg::alu_xor: alu_out = op_a ^ op_b;
            rv32i_pkg::alu_srl: alu_out = op_a >> shamt;
            rv32i_pkg::alu_or:  alu_out = op_a | op_b;
            default:            alu_out = op_a & op_b;
        endcase
    end

    // comparator, slt and sltu
    always_comb begin
        case (i_ctrl.cmpop)
            rv32i_pkg::cmp_lt:  cmp_out = $signed(op_a) < $signed(op_b);
            rv32i_pkg::cmp_ltu: cmp_out = op_a < op_b;
            default:            cmp_out = 1'b0;
        endcase
    end

    // result select
    always_comb begin
        case (i_ctrl.result_sel)
            rv32i_pkg::res_cmp:  result = {{(rv32i_pkg::XLEN-1){1'b0}}, cmp_out};
            rv32i_pkg::res_uimm: result = i_ctrl.imm;
            default:             result = alu_out;
        endcase
    end

    // writeback packet, value forced to zero on a trap
    assign wb_d.rd    = i_ctrl.rd;
    assign wb_d.value = i_ctrl.trap ? '0 : result;
    assign wb_d.we    = i_ctrl.we;
    assign wb_d.trap  = i_ctrl.trap;

    pipe_reg #(
        .payload_t(rv32i_pkg::wb_t)
    ) i_pipe_reg (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .i_data  (wb_d),
        .o_valid (o_valid),
        .i_ready (i_ready),
        .o_data  (o_wb)
    );

endmodule : execute_stage

/* hw/alu_pipe_top.sv */
module alu_pipe_top (
    input  logic              clk,
    input  logic              rst,
    // instruction input
    input  logic              i_in_valid,
    output logic              o_in_ready,
    input  rv32i_pkg::issue_t i_in,
    // writeback output
    output logic              o_out_valid,
    input  logic              i_out_ready,
    output rv32i_pkg::wb_t    o_out
);

    // decode to execute link
    logic                  dec_valid;
    logic                  dec_ready;
    rv32i_pkg::exec_ctrl_t dec_ctrl;

    // stage 1, decode and trap check
    decode_stage i_decode_stage (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_in_valid),
        .o_ready (o_in_ready),
        .i_issue (i_in),
        .o_valid (dec_valid),
        .i_ready (dec_ready),
        .o_ctrl  (dec_ctrl)
    );

    // stage 2, alu, comparator, writeback packet
    // its ready feeds back into decode, so back-pressure ripples upstream
    execute_stage i_execute_stage (
        .clk     (clk),
        .rst     (rst),
        .i_valid (dec_valid),
        .o_ready (dec_ready),
        .i_ctrl  (dec_ctrl),
        .o_valid (o_out_valid),
        .i_ready (i_out_ready),
        .o_wb    (o_out)
    );

endmodule : alu_pipe_top

/* sim/alu_pipe_checker.sv */
module alu_pipe_checker (
    input logic              clk,
    input logic              rst,
    input logic              i_in_valid,
    input logic              o_in_ready,
    input rv32i_pkg::issue_t i_in,
    input logic              o_out_valid,
    input logic              i_out_ready,
    input rv32i_pkg::wb_t    o_out
);

    // expected packets in flight, oldest at rd_ptr
    rv32i_pkg::wb_t exp_mem [4];
    logic [31:0]    instr_mem [4];
    logic [1:0]     wr_ptr;
    logic [1:0]     rd_ptr;
    logic [2:0]     count;
    logic           in_fire;
    logic           out_fire;
    rv32i_pkg::wb_t in_exp;
    rv32i_pkg::wb_t exp_head;
    logic [31:0]    head_instr;
    // failed assertions so far
    int             err_count = 0;

    // writeback packet from the rv32i rules for the supported subset
    function automatic rv32i_pkg::wb_t ref_wb(input rv32i_pkg::issue_t t);
        rv32i_pkg::wb_t w;
        logic [31:0]    imm_i;
        logic [31:0]    imm_u;
        logic [31:0]    b;
        logic [4:0]     sh;
        logic           is_reg;
        logic           alt;
        imm_i  = {{20{t.instr[31]}}, t.instr[31:20]};
        imm_u  = {t.instr[31:12], 12'h000};
        is_reg = (t.instr[6:0] == 7'b0110011);
        // instr bit 30 picks sub and sra
        alt    = t.instr[30];
        b      = is_reg ? t.rs2_val : imm_i;
        sh     = b[4:0];
        w.rd    = t.instr[11:7];
        w.we    = (t.instr[11:7] != 5'd0);
        w.trap  = 1'b0;
        w.value = '0;
        case (t.instr[6:0])
            // lui
            7'b0110111: w.value = imm_u;
            // auipc
            7'b0010111: w.value = t.pc + imm_u;
            7'b0010011, 7'b0110011: begin
                case (t.instr[14:12])
                    3'd0: w.value = (is_reg && alt) ? t.rs1_val - b : t.rs1_val + b;
                    3'd1: w.value = t.rs1_val << sh;
                    3'd2: w.value = {31'd0, $signed(t.rs1_val) < $signed(b)};
                    3'd3: w.value = {31'd0, t.rs1_val < b};
                    3'd4: w.value = t.rs1_val ^ b;
                    3'd5: begin
                        if (alt) begin
                            w.value = $signed(t.rs1_val) >>> sh;
                        end else begin
                            w.value = t.rs1_val >> sh;
                        end
                    end
                    3'd6: w.value = t.rs1_val | b;
                    default: w.value = t.rs1_val & b;
                endcase
            end
            default: begin
                // everything else is unsupported, nothing gets written
                w.trap = 1'b1;
                w.we   = 1'b0;
            end
        endcase
        return w;
    endfunction

    // mnemonic used as the test name in error lines
    function automatic string op_name(input logic [31:0] instr);
        logic is_reg;
        is_reg = (instr[6:0] == 7'b0110011);
        if (instr[6:0] == 7'b0110111) begin
            return "lui";
        end else if (instr[6:0] == 7'b0010111) begin
            return "auipc";
        end else if (!is_reg && instr[6:0] != 7'b0010011) begin
            return "trap";
        end
        case (instr[14:12])
            3'd0: return is_reg ? (instr[30] ? "sub" : "add") : "addi";
            3'd1: return is_reg ? "sll" : "slli";
            3'd2: return is_reg ? "slt" : "slti";
            3'd3: return is_reg ? "sltu" : "sltiu";
            3'd4: return is_reg ? "xor" : "xori";
            3'd5: return instr[30] ? (is_reg ? "sra" : "srai") : (is_reg ? "srl" : "srli");
            3'd6: return is_reg ? "or" : "ori";
            default: return is_reg ? "and" : "andi";
        endcase
    endfunction

    assign in_fire    = i_in_valid && o_in_ready;
    assign out_fire   = o_out_valid && i_out_ready;
    assign in_exp     = ref_wb(i_in);
    assign exp_head   = exp_mem[rd_ptr];
    assign head_instr = instr_mem[rd_ptr];

    // push on input transfer, pop on output transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_fire) begin
                exp_mem[wr_ptr]   <= in_exp;
                instr_mem[wr_ptr] <= i_in.instr;
                wr_ptr            <= wr_ptr + 2'd1;
            end
            if (out_fire) begin
                rd_ptr <= rd_ptr + 2'd1;
            end
            count <= count + {2'b00, in_fire} - {2'b00, out_fire};
        end
    end

    // in order, nothing lost or swapped
    a_value: assert property (@(posedge clk) disable iff (rst)
        out_fire && count != 3'd0 |-> o_out == exp_head)
        else begin
            $error("error %s: expected %h, actual %h", op_name($sampled(head_instr)),
                   $sampled(exp_head), $sampled(o_out));
            err_count++;
        end

    // no output without a pending input
    a_no_extra: assert property (@(posedge clk) disable iff (rst)
        out_fire |-> count != 3'd0)
        else begin
            $error("output transfer with no pending input");
            err_count++;
        end

    // data frozen while stalled
    a_stable: assert property (@(posedge clk) disable iff (rst)
        o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out))
        else begin
            $error("output changed or dropped while stalled");
            err_count++;
        end

    // two cycle latency with the output side ready
    a_latency: assert property (@(posedge clk) disable iff (rst)
        in_fire ##1 i_out_ready |=> o_out_valid && o_out == $past(in_exp, 2))
        else begin
            $error("output did not arrive 2 cycles after its input transfer");
            err_count++;
        end

    // nothing valid right after reset
    a_reset: assert property (@(posedge clk) rst |=> !o_out_valid)
        else begin
            $error("output valid in the cycle after reset");
            err_count++;
        end

endmodule : alu_pipe_checker

bind alu_pipe_top alu_pipe_checker i_alu_pipe_checker (.*);

/* sim/alu_pipe_tb.sv */
module alu_pipe_tb;

    // instructions sent through the pipeline
    localparam int N_TESTS = 400;
    localparam int SEED    = 32'h4330;
    localparam int PERIOD  = 100;

    logic              clk;
    logic              rst;
    logic              in_valid;
    logic              in_ready;
    rv32i_pkg::issue_t in_data;
    logic              out_valid;
    logic              out_ready;
    rv32i_pkg::wb_t    out_data;

    int                seed;
    int                issued;
    int                received;
    logic              in_take;
    logic [31:0]       rnd;
    rv32i_pkg::issue_t item;

    alu_pipe_top i_alu_pipe_top (
        .clk         (clk),
        .rst         (rst),
        .i_in_valid  (in_valid),
        .o_in_ready  (in_ready),
        .i_in        (in_data),
        .o_out_valid (out_valid),
        .i_out_ready (out_ready),
        .o_out       (out_data)
    );

    always #(PERIOD / 2) clk = ~clk;

    // random instruction, mostly supported opcodes
    task automatic make_issue(output rv32i_pkg::issue_t t);
        logic [31:0] r;
        logic [6:0]  opc;
        r         = $random(seed);
        t.instr   = $random(seed);
        t.pc      = $random(seed);
        t.rs1_val = $random(seed);
        t.rs2_val = $random(seed);
        t.pc[1:0] = 2'b00;
        case (r[2:0])
            3'd0, 3'd1: opc = 7'b0010011;
            3'd2, 3'd3: opc = 7'b0110011;
            3'd4: opc = 7'b0110111;
            3'd5: opc = 7'b0010111;
            3'd6: begin
                // load, store, branch, jal, jalr or an unknown opcode
                case (r[5:3])
                    3'd0: opc = 7'b0000011;
                    3'd1: opc = 7'b0100011;
                    3'd2: opc = 7'b1100011;
                    3'd3: opc = 7'b1101111;
                    3'd4: opc = 7'b1100111;
                    default: opc = 7'b0001011;
                endcase
            end
            default: begin
                // slt or sltu, operands differ only in the sign bit
                opc            = 7'b0110011;
                t.instr[14:12] = {2'b01, r[6]};
                t.rs2_val      = t.rs1_val ^ 32'h8000_0000;
            end
        endcase
        t.instr[6:0] = opc;
        // register ops get a legal funct7, only bit 30 varies
        if (opc == 7'b0110011) begin
            t.instr[31:25] = {1'b0, t.instr[30], 5'b00000};
        end
        // some writes go to x0
        if (r[9:7] == 3'd0) begin
            t.instr[11:7] = 5'd0;
        end
    endtask

    // watchdog, 10 cycles per instruction plus reset and drain
    initial begin
        #(N_TESTS * 10 * PERIOD + 50 * PERIOD);
        $display("timeout: the pipeline did not deliver all outputs in time");
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    // stop at the first failed assertion
    always @(negedge clk) begin
        if (i_alu_pipe_top.i_alu_pipe_checker.err_count != 0) begin
            $display("Errors found");
            $fatal(1, "a checker assertion failed");
        end
    end

    initial begin
        seed      = SEED;
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        issued    = 0;
        received  = 0;
        repeat (5) @(posedge clk);
        rst       <= 1'b0;
        out_ready <= 1'b1;
        while (received < N_TESTS) begin
            // transfers due at the coming edge
            @(negedge clk);
            in_take = in_valid && in_ready;
            if (out_valid && out_ready) begin
                received++;
            end
            @(posedge clk);
            if (!in_valid || in_take) begin
                if (issued < N_TESTS) begin
                    make_issue(item);
                    in_valid <= 1'b1;
                    in_data  <= item;
                    issued++;
                end else begin
                    in_valid <= 1'b0;
                end
            end
            // full rate first, random back-pressure in the second half
            rnd = $random(seed);
            out_ready <= (issued <= N_TESTS / 2) ? 1'b1 : rnd[0];
        end
        // idle drain, a stray output would trip the checker here
        out_ready <= 1'b1;
        repeat (5) @(posedge clk);
        // assertions of the last edge have reported by the falling edge
        @(negedge clk);
        if (i_alu_pipe_top.i_alu_pipe_checker.err_count == 0 &&
            i_alu_pipe_top.i_alu_pipe_checker.count == 3'd0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("checker reported a failure or inputs are still pending at the end");
            $display("Errors found");
            $fatal(1, "end of run check failed");
        end
    end

endmodule : alu_pipe_tb

/* verilog.f */
hw/rv32i_pkg.sv
hw/pipe_reg.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/alu_pipe_top.sv
sim/alu_pipe_checker.sv
sim/alu_pipe_tb.sv

/* run.sh */
#!/bin/sh
# build and run the pipeline testbench with Verilator
set -e

verilator --binary --assert --timing -f verilog.f --top-module alu_pipe_tb -Mdir obj_dir

# keep running after an assertion so the testbench reports it
./obj_dir/Valu_pipe_tb +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
